//--- Bender.yml
package:
  name: reorder_engine

sources:
  - rtl/rob_pkg.sv
  - rtl/rob_resp_fifo.sv
  - rtl/rob_req_table.sv
  - rtl/rob_retire.sv
  - rtl/reorder_engine.sv
  - target: simulation
    files:
      - testbench/tb_reorder_engine.sv

//--- reorder_engine.f
rtl/rob_pkg.sv
rtl/rob_resp_fifo.sv
rtl/rob_req_table.sv
rtl/rob_retire.sv
rtl/reorder_engine.sv
testbench/tb_reorder_engine.sv

//--- rtl/reorder_engine.sv
`timescale 1ns/1ns

module reorder_engine
  import rob_pkg::*;
#(
  parameter int NUM_SLOTS  = DEF_SLOTS,
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst,
  // read requests
  input  logic     i_req_valid,
  input  rd_req_t  i_req,
  output logic     o_req_rdy,
  // read responses, out of order
  input  logic     i_resp_valid,
  input  rd_resp_t i_resp,
  output logic     o_resp_rdy,
  // in-order release
  output logic     o_axi_valid,
  output rob_out_t o_axi_pkt,
  input  logic     i_axi_rdy,
  output logic     o_pgen_valid,
  output rob_out_t o_pgen_pkt,
  input  logic     i_pgen_rdy
);

  logic                         head_valid;
  rd_resp_t                     head;
  logic                         pop;
  logic                         fill_valid;
  rob_fill_t                    fill;
  logic                         oldest_filled;
  logic [$clog2(NUM_SLOTS)-1:0] oldest_idx;
  rd_op_e                       oldest_op;
  logic                         retire;

  rob_resp_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_resp_fifo (
    .clk          (clk),
    .rst          (rst),
    .i_push       (i_resp_valid),
    .i_data       (i_resp),
    .o_full_n     (o_resp_rdy),
    .o_head_valid (head_valid),
    .o_head       (head),
    .i_pop        (pop)
  );

  rob_req_table #(
    .NUM_SLOTS (NUM_SLOTS)
  ) u_req_table (
    .clk             (clk),
    .rst             (rst),
    .i_req_valid     (i_req_valid),
    .i_req           (i_req),
    .o_req_rdy       (o_req_rdy),
    .i_head_valid    (head_valid),
    .i_head          (head),
    .o_pop           (pop),
    .o_fill_valid    (fill_valid),
    .o_fill          (fill),
    .o_oldest_filled (oldest_filled),
    .o_oldest_idx    (oldest_idx),
    .o_oldest_op     (oldest_op),
    .i_retire        (retire)
  );

  rob_retire #(
    .NUM_SLOTS (NUM_SLOTS)
  ) u_retire (
    .clk             (clk),
    .rst             (rst),
    .i_fill_valid    (fill_valid),
    .i_fill          (fill),
    .i_oldest_filled (oldest_filled),
    .i_oldest_idx    (oldest_idx),
    .i_oldest_op     (oldest_op),
    .o_retire        (retire),
    .o_axi_valid     (o_axi_valid),
    .o_axi_pkt       (o_axi_pkt),
    .i_axi_rdy       (i_axi_rdy),
    .o_pgen_valid    (o_pgen_valid),
    .o_pgen_pkt      (o_pgen_pkt),
    .i_pgen_rdy      (i_pgen_rdy)
  );

endmodule

//--- rtl/rob_pkg.sv
package rob_pkg;

  // address field widths of a read tag
  localparam int CH_W  = 2;
  localparam int BK_W  = 4;
  localparam int ROW_W = 14;
  localparam int COL_W = 6;

  // response payload width
  localparam int DATA_W = 64;

  // defaults handed down by the top level
  localparam int DEF_SLOTS      = 16;
  localparam int DEF_FIFO_DEPTH = 4;

  // fill index is sized for up to 256 slots
  localparam int FILL_IDX_W = 8;

  typedef enum logic [1:0] {
    READ     = 2'd0,
    READ_SBK = 2'd1,
    READ_MAC = 2'd2,
    READ_AF  = 2'd3
  } rd_op_e;

  typedef struct packed {
    logic [CH_W-1:0]  ch;
    logic [BK_W-1:0]  bk;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
  } rd_tag_t;

  typedef struct packed {
    rd_tag_t tag;
    rd_op_e  op;
  } rd_req_t;

  typedef struct packed {
    rd_tag_t           tag;
    logic [DATA_W-1:0] data;
  } rd_resp_t;

  // matched response on its way into the data memory
  typedef struct packed {
    logic [FILL_IDX_W-1:0] idx;
    logic [DATA_W-1:0]     data;
  } rob_fill_t;

  typedef struct packed {
    rd_op_e            op;
    logic [DATA_W-1:0] data;
  } rob_out_t;

endpackage

//--- rtl/rob_req_table.sv
`timescale 1ns/1ns

module rob_req_table
  import rob_pkg::*;
#(
  parameter int NUM_SLOTS = DEF_SLOTS
) (
  input  logic                         clk,
  input  logic                         rst,
  // request side
  input  logic                         i_req_valid,
  input  rd_req_t                      i_req,
  output logic                         o_req_rdy,
  // response fifo head
  input  logic                         i_head_valid,
  input  rd_resp_t                     i_head,
  output logic                         o_pop,
  // fill toward data memory
  output logic                         o_fill_valid,
  output rob_fill_t                    o_fill,
  // oldest slot status
  output logic                         o_oldest_filled,
  output logic [$clog2(NUM_SLOTS)-1:0] o_oldest_idx,
  output rd_op_e                       o_oldest_op,
  input  logic                         i_retire
);

  localparam int IDX_W = $clog2(NUM_SLOTS);
  localparam int CNT_W = $clog2(NUM_SLOTS + 1);

  rd_tag_t              slot_tag [NUM_SLOTS];
  rd_op_e               slot_op  [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] pending;
  logic [NUM_SLOTS-1:0] filled;
  logic [IDX_W-1:0]     oldest_ptr;
  logic [IDX_W-1:0]     empty_ptr;
  logic [CNT_W-1:0]     count;
  logic                 alloc;
  logic [NUM_SLOTS-1:0] hit;
  logic                 match;
  logic [IDX_W-1:0]     match_idx;

  function automatic logic [IDX_W-1:0] next_slot(input logic [IDX_W-1:0] idx);
    if (idx == IDX_W'(NUM_SLOTS - 1)) begin
      return '0;
    end
    return idx + 1'b1;
  endfunction

  // exact full test
  assign o_req_rdy = (count < CNT_W'(NUM_SLOTS));
  assign alloc     = i_req_valid && o_req_rdy;

  // slots still waiting for data with the head's tag
  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      hit[i] = pending[i] && !filled[i] && (slot_tag[i] == i_head.tag);
    end
  end

  // walk from youngest offset back to oldest so the oldest hit wins
  always_comb begin
    int unsigned pos;
    match     = 1'b0;
    match_idx = '0;
    for (int k = NUM_SLOTS - 1; k >= 0; k--) begin
      pos = int'(oldest_ptr) + k;
      if (pos >= NUM_SLOTS) begin
        pos = pos - NUM_SLOTS;
      end
      if (hit[pos]) begin
        match     = 1'b1;
        match_idx = IDX_W'(pos);
      end
    end
    match = match && i_head_valid;
  end

  // head leaves every cycle it is presented, matched or not
  assign o_pop        = i_head_valid;
  assign o_fill_valid = match;
  assign o_fill.idx   = FILL_IDX_W'(match_idx);
  assign o_fill.data  = i_head.data;

  assign o_oldest_filled = filled[oldest_ptr];
  assign o_oldest_idx    = oldest_ptr;
  assign o_oldest_op     = slot_op[oldest_ptr];

  always_ff @(posedge clk) begin
    if (alloc) begin
      slot_tag[empty_ptr] <= i_req.tag;
      slot_op[empty_ptr]  <= i_req.op;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pending    <= '0;
      filled     <= '0;
      oldest_ptr <= '0;
      empty_ptr  <= '0;
      count      <= '0;
    end else begin
      if (match) begin
        filled[match_idx] <= 1'b1;
      end
      // retire frees the oldest slot
      if (i_retire) begin
        pending[oldest_ptr] <= 1'b0;
        filled[oldest_ptr]  <= 1'b0;
        oldest_ptr          <= next_slot(oldest_ptr);
      end
      if (alloc) begin
        pending[empty_ptr] <= 1'b1;
        empty_ptr          <= next_slot(empty_ptr);
      end
      case ({alloc, i_retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // count and ring pointers agree with the slot flags
  a_alloc_free_slot: assert property (@(posedge clk) disable iff (rst)
    alloc |-> !pending[empty_ptr] && !filled[empty_ptr])
    else $error("allocation into an occupied slot");

  a_retire_filled: assert property (@(posedge clk) disable iff (rst)
    i_retire |-> o_oldest_filled)
    else $error("retire of an oldest slot without data");

endmodule

//--- rtl/rob_resp_fifo.sv
`timescale 1ns/1ns

module rob_resp_fifo
  import rob_pkg::*;
#(
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_push,
  input  rd_resp_t i_data,
  output logic     o_full_n,
  output logic     o_head_valid,
  output rd_resp_t o_head,
  input  logic     i_pop
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  rd_resp_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push_ok;
  logic             pop_ok;

  // ring pointer step, wraps at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign o_full_n     = (count != CNT_W'(FIFO_DEPTH));
  assign o_head_valid = (count != '0);
  assign o_head       = mem[rd_ptr];

  // push is qualified here, the source only drives valid
  assign push_ok = i_push && o_full_n;
  assign pop_ok  = i_pop && o_head_valid;

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop_ok) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the table must only pop a presented head
  a_pop_not_empty: assert property (@(posedge clk) disable iff (rst)
    i_pop |-> o_head_valid)
    else $error("response fifo popped while empty");

endmodule

//--- rtl/rob_retire.sv
`timescale 1ns/1ns

module rob_retire
  import rob_pkg::*;
#(
  parameter int NUM_SLOTS = DEF_SLOTS
) (
  input  logic                         clk,
  input  logic                         rst,
  // fill from the table
  input  logic                         i_fill_valid,
  input  rob_fill_t                    i_fill,
  // oldest slot status
  input  logic                         i_oldest_filled,
  input  logic [$clog2(NUM_SLOTS)-1:0] i_oldest_idx,
  input  rd_op_e                       i_oldest_op,
  output logic                         o_retire,
  // AXI bridge port
  output logic                         o_axi_valid,
  output rob_out_t                     o_axi_pkt,
  input  logic                         i_axi_rdy,
  // packet generator port
  output logic                         o_pgen_valid,
  output rob_out_t                     o_pgen_pkt,
  input  logic                         i_pgen_rdy
);

  localparam int IDX_W = $clog2(NUM_SLOTS);

  logic [DATA_W-1:0] data_mem [NUM_SLOTS];
  rob_out_t          out_pkt;
  logic              out_valid;
  // set when the held word belongs to the packet generator
  logic              out_pgen;
  logic              out_taken;
  logic              load;

  assign out_taken = out_valid && (out_pgen ? i_pgen_rdy : i_axi_rdy);

  // refill on the same edge the current word leaves
  assign load     = i_oldest_filled && (!out_valid || out_taken);
  assign o_retire = load;

  always_ff @(posedge clk) begin
    if (i_fill_valid) begin
      data_mem[i_fill.idx[IDX_W-1:0]] <= i_fill.data;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_pkt.op   <= i_oldest_op;
      out_pkt.data <= data_mem[i_oldest_idx];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_pgen  <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
      // plain reads go to the AXI bridge
      out_pgen  <= (i_oldest_op != READ);
    end else if (out_taken) begin
      out_valid <= 1'b0;
    end
  end

  assign o_axi_valid  = out_valid && !out_pgen;
  assign o_pgen_valid = out_valid && out_pgen;
  assign o_axi_pkt    = out_pkt;
  assign o_pgen_pkt   = out_pkt;

  // a stalled word waits unchanged on its port
  a_axi_hold: assert property (@(posedge clk) disable iff (rst)
    o_axi_valid && !i_axi_rdy |=> o_axi_valid && $stable(o_axi_pkt))
    else $error("axi word changed before transfer");

  a_pgen_hold: assert property (@(posedge clk) disable iff (rst)
    o_pgen_valid && !i_pgen_rdy |=> o_pgen_valid && $stable(o_pgen_pkt))
    else $error("pgen word changed before transfer");

endmodule

//--- testbench/tb_reorder_engine.sv
`timescale 1ns/1ns

module tb_reorder_engine
  import rob_pkg::*;
;

  localparam int SLOTS = DEF_SLOTS;
  // rough cycle budget of each test
  localparam int LEN_RESET   = 8;
  localparam int LEN_INORDER = 60;
  localparam int LEN_MIX     = 80;
  localparam int LEN_SHARED  = 30;
  localparam int LEN_BACKPR  = 200;
  localparam int LEN_FULL    = 100;
  localparam int RUN_LIMIT   =
    4 * (LEN_RESET + LEN_INORDER + LEN_MIX + LEN_SHARED + LEN_BACKPR + LEN_FULL);

  typedef struct packed {
    rd_tag_t           tag;
    rd_op_e            op;
    logic [DATA_W-1:0] data;
    logic              has_data;
  } ref_entry_t;

  logic     clk;
  logic     rst;
  logic     i_req_valid;
  rd_req_t  i_req;
  logic     o_req_rdy;
  logic     i_resp_valid;
  rd_resp_t i_resp;
  logic     o_resp_rdy;
  logic     o_axi_valid;
  rob_out_t o_axi_pkt;
  logic     i_axi_rdy;
  logic     o_pgen_valid;
  rob_out_t o_pgen_pkt;
  logic     i_pgen_rdy;

  ref_entry_t  ref_q [$];
  rd_tag_t     issued [$];
  logic [31:0] lfsr = 32'h2f2c;
  logic        rnd_rdy = 1'b0;
  int          cycles = 0;
  int          out_cnt = 0;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          test_num = 0;
  int          err_at_start = 0;
  int          tag_seq = 0;

  reorder_engine #(
    .NUM_SLOTS  (SLOTS),
    .FIFO_DEPTH (DEF_FIFO_DEPTH)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .i_req_valid  (i_req_valid),
    .i_req        (i_req),
    .o_req_rdy    (o_req_rdy),
    .i_resp_valid (i_resp_valid),
    .i_resp       (i_resp),
    .o_resp_rdy   (o_resp_rdy),
    .o_axi_valid  (o_axi_valid),
    .o_axi_pkt    (o_axi_pkt),
    .i_axi_rdy    (i_axi_rdy),
    .o_pgen_valid (o_pgen_valid),
    .o_pgen_pkt   (o_pgen_pkt),
    .i_pgen_rdy   (i_pgen_rdy)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= RUN_LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic flag_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("ERROR %s expected %h got %h", name, exp, act);
    err_cnt++;
  endtask

  task automatic flag_failure(input string msg);
    $display("%0t: %s", $time, msg);
    err_cnt++;
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic get_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  // inputs move 10 ns after the edge
  task automatic tick();
    logic [63:0] b;
    @(posedge clk);
    #10;
    if (rnd_rdy) begin
      get_bits(2, b);
      i_axi_rdy  = b[0];
      i_pgen_rdy = b[1];
    end
  endtask

  task automatic send_req(input rd_tag_t tag, input rd_op_e op);
    logic       taken;
    ref_entry_t e;
    i_req_valid = 1'b1;
    i_req.tag   = tag;
    i_req.op    = op;
    taken       = 1'b0;
    while (!taken) begin
      taken = o_req_rdy;
      tick();
    end
    i_req_valid = 1'b0;
    e.tag      = tag;
    e.op       = op;
    e.data     = '0;
    e.has_data = 1'b0;
    ref_q.push_back(e);
    issued.push_back(tag);
  endtask

  // the response fills the oldest request of that tag still without data
  task automatic send_resp(input rd_tag_t tag);
    logic [63:0] d;
    logic        taken;
    ref_entry_t  e;
    int          idx;
    get_bits(DATA_W, d);
    i_resp_valid = 1'b1;
    i_resp.tag   = tag;
    i_resp.data  = d;
    taken        = 1'b0;
    while (!taken) begin
      taken = o_resp_rdy;
      tick();
    end
    i_resp_valid = 1'b0;
    idx = -1;
    for (int k = 0; k < ref_q.size(); k++) begin
      if (idx < 0 && ref_q[k].tag == tag && !ref_q[k].has_data) begin
        idx = k;
      end
    end
    if (idx >= 0) begin
      e          = ref_q[idx];
      e.data     = d;
      e.has_data = 1'b1;
      ref_q[idx] = e;
    end
  endtask

  // col field keeps outstanding tags distinct
  task automatic issue_reads(input int n, input logic mixed);
    logic [63:0] b;
    rd_tag_t     tag;
    rd_op_e      op;
    for (int i = 0; i < n; i++) begin
      get_bits(28, b);
      tag     = rd_tag_t'(b[25:0]);
      tag.col = COL_W'(tag_seq);
      tag_seq++;
      op = mixed ? rd_op_e'(b[27:26]) : READ;
      send_req(tag, op);
    end
  endtask

  task automatic answer_shuffled();
    rd_tag_t     order [$];
    rd_tag_t     tmp;
    logic [63:0] b;
    int          j;
    order = issued;
    for (int i = order.size() - 1; i > 0; i--) begin
      get_bits(8, b);
      j        = int'(b[7:0]) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    foreach (order[i]) begin
      send_resp(order[i]);
    end
    issued.delete();
  endtask

  task automatic start_test();
    test_num++;
    err_at_start = err_cnt;
  endtask

  task automatic finish_test(input string name);
    while (ref_q.size() != 0) begin
      tick();
    end
    repeat (4) tick();
    a_no_stray: assert (!o_axi_valid && !o_pgen_valid)
      else flag_failure("extra word released after all requests were answered");
    if (err_cnt == err_at_start) begin
      pass_cnt++;
      $display("test %0d %s: passed", test_num, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_num, name, err_cnt - err_at_start);
    end
  endtask

  // every transfer is matched against the front of the reference queue
  always @(negedge clk) begin : monitor
    rob_out_t   got;
    ref_entry_t want;
    string      port;
    if (!rst && ((o_axi_valid && i_axi_rdy) || (o_pgen_valid && i_pgen_rdy))) begin
      got  = o_axi_valid ? o_axi_pkt : o_pgen_pkt;
      port = o_axi_valid ? "o_axi_pkt" : "o_pgen_pkt";
      a_word_expected: assert (ref_q.size() > 0)
        else flag_failure("word released with no request outstanding");
      if (ref_q.size() > 0) begin
        want = ref_q.pop_front();
        a_has_data: assert (want.has_data)
          else flag_failure("word released before its response was sent");
        a_op: assert (got.op == want.op)
          else flag_value({port, ".op"}, 64'(want.op), 64'(got.op));
        a_data: assert (got.data == want.data)
          else flag_value({port, ".data"}, want.data, got.data);
        a_route: assert (o_pgen_valid == (want.op != READ))
          else flag_failure("word released on the wrong output port");
      end
      out_cnt++;
    end
  end

  a_axi_hold: assert property (@(posedge clk) disable iff (rst)
    o_axi_valid && !i_axi_rdy |=> o_axi_valid && $stable(o_axi_pkt))
    else flag_failure("stalled axi word changed or vanished");

  a_pgen_hold: assert property (@(posedge clk) disable iff (rst)
    o_pgen_valid && !i_pgen_rdy |=> o_pgen_valid && $stable(o_pgen_pkt))
    else flag_failure("stalled pgen word changed or vanished");

  a_one_port: assert property (@(posedge clk) disable iff (rst)
    !(o_axi_valid && o_pgen_valid))
    else flag_failure("both output ports valid at once");

  initial begin
    rd_tag_t shared_tag;
    rd_tag_t other_tag;
    int      n0;
    clk          = 1'b0;
    rst          = 1'b1;
    i_req_valid  = 1'b0;
    i_req        = '0;
    i_resp_valid = 1'b0;
    i_resp       = '0;
    i_axi_rdy    = 1'b1;
    i_pgen_rdy   = 1'b1;
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;

    start_test();
    a_rst_axi: assert (!o_axi_valid) else flag_value("o_axi_valid", 0, o_axi_valid);
    a_rst_pgen: assert (!o_pgen_valid) else flag_value("o_pgen_valid", 0, o_pgen_valid);
    a_rst_req: assert (o_req_rdy) else flag_value("o_req_rdy", 1, o_req_rdy);
    a_rst_resp: assert (o_resp_rdy) else flag_value("o_resp_rdy", 1, o_resp_rdy);
    finish_test("reset state");

    start_test();
    issue_reads(8, 1'b0);
    answer_shuffled();
    finish_test("shuffled plain reads");

    start_test();
    issue_reads(12, 1'b1);
    answer_shuffled();
    finish_test("mixed opcodes");

    // older request of a shared tag takes the first response
    start_test();
    shared_tag = rd_tag_t'(26'h2a5_1c3);
    other_tag  = rd_tag_t'(26'h0f0_e21);
    send_req(shared_tag, READ);
    send_req(other_tag, READ_SBK);
    send_req(shared_tag, READ_MAC);
    send_resp(shared_tag);
    send_resp(other_tag);
    send_resp(shared_tag);
    issued.delete();
    finish_test("shared tag");

    start_test();
    rnd_rdy = 1'b1;
    issue_reads(8, 1'b1);
    answer_shuffled();
    issue_reads(8, 1'b1);
    answer_shuffled();
    while (ref_q.size() != 0) begin
      tick();
    end
    rnd_rdy    = 1'b0;
    i_axi_rdy  = 1'b1;
    i_pgen_rdy = 1'b1;
    finish_test("random back-pressure");

    start_test();
    issue_reads(SLOTS, 1'b1);
    a_full: assert (!o_req_rdy) else flag_value("o_req_rdy", 0, o_req_rdy);
    n0 = out_cnt;
    send_resp(issued[0]);
    void'(issued.pop_front());
    while (out_cnt == n0) begin
      tick();
    end
    tick();
    a_reopen: assert (o_req_rdy) else flag_value("o_req_rdy", 1, o_req_rdy);
    answer_shuffled();
    finish_test("table full");

    $display("tests passed %0d failed %0d errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
